//--- files.f
rtl/kbd_pkg.sv
rtl/keymap_ram.sv
rtl/spectrum_matrix.sv
rtl/key_activity_monitor.sv
rtl/special_keys.sv
rtl/translate_ctrl.sv
rtl/kbd_top.sv
testbench/kbd_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= kbd_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/kbd_tb.sv
module kbd_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import kbd_pkg::*;

  localparam int CPU_DEPTH = 2**CPU_ADDR_W;
  localparam int SCAN_GAP  = 12;
  localparam int ACK_LIMIT = 50;
  localparam int EVENTS    = 80;
  // Budgets per test in clock cycles, summed for the watchdog
  localparam int T2_CYCLES = 2 * CPU_DEPTH * 16;
  localparam int T3_CYCLES = (EVENTS + 20) * 40 + 800;
  localparam int T4_CYCLES = 30 * 40 + 800;
  localparam int T5_CYCLES = 4 * 64 * 16 + 1200;
  localparam int TIMEOUT_CYCLES = 100 + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + 5000;

  logic                   clk;
  logic                   rst;
  logic                   scan_received;
  logic [SCAN_W-1:0]      scan_code;
  logic                   extended;
  logic                   released;
  logic [MATRIX_ROWS-1:0] sp_row;
  logic [MATRIX_COLS-1:0] sp_col;
  logic [7:0]             cpu_din;
  logic [7:0]             cpu_dout;
  logic                   cpu_read;
  logic                   cpu_write;
  logic                   cpu_rewind;
  logic                   cpu_ack;
  logic                   user_reset;
  logic                   master_reset;
  logic                   user_nmi;
  logic                   joy_up;
  logic                   joy_down;
  logic                   joy_left;
  logic                   joy_right;
  logic                   joy_fire;

  // Testbench copy of both maps, indexed like the CPU address
  logic [7:0]             map_copy [CPU_DEPTH];
  logic [MATRIX_COLS-1:0] model_rows [MATRIX_ROWS];
  logic                   m_shift;
  logic                   m_ctrl;
  logic                   m_alt;
  logic                   check_en;
  int                     errors;
  int                     checks;

  kbd_top kbd_top_inst (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ----------------------------------------
  // Reference model and checks
  // ----------------------------------------
  function automatic logic [MATRIX_COLS-1:0] expected_col(input logic [7:0] row_sel);
    logic [MATRIX_COLS-1:0] col;
    col = '1;
    for (int r = 0; r < MATRIX_ROWS; r++) begin
      if (!row_sel[r]) begin
        col = col & model_rows[r];
      end
    end
    return col;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Compare in the middle of the cycle, away from the clock edge
  always @(negedge clk) begin
    if (check_en) begin
      check_value("sp_col", 32'(sp_col), 32'(expected_col(sp_row)));
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_entry(input logic [7:0] entry, input logic rel);
    if (rel) begin
      model_rows[entry[7:5]] = model_rows[entry[7:5]] | entry[4:0];
    end else begin
      model_rows[entry[7:5]] = model_rows[entry[7:5]] & ~entry[4:0];
    end
  endtask

  task automatic check_matrix(input int n);
    for (int i = 0; i < n; i++) begin
      sp_row   = (i == 0) ? 8'h00 : 8'($urandom());
      check_en = 1'b1;
      next_cycle();
    end
    check_en = 1'b0;
  endtask

  task automatic check_specials(input logic [7:0] exp);
    check_value("joy_up,joy_down,joy_left,joy_right,joy_fire,user_nmi,user_reset,master_reset",
                32'({joy_up, joy_down, joy_left, joy_right, joy_fire,
                     user_nmi, user_reset, master_reset}), 32'(exp));
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic send_key(input logic [KEY_CODE_W-1:0] key, input logic rel);
    logic [KEYMAP_ADDR_W-1:0] idx;
    scan_received = 1'b1;
    scan_code     = key[SCAN_W-1:0];
    extended      = key[8];
    released      = rel;
    next_cycle();
    scan_received = 1'b0;
    if (key == KEY_LSHIFT || key == KEY_RSHIFT) m_shift = !rel;
    if (key == KEY_LCTRL || key == KEY_RCTRL) m_ctrl = !rel;
    if (key == KEY_LALT || key == KEY_RALT) m_alt = !rel;
    // The lookup already sees the modifier change made by this scan
    idx = {m_alt, m_ctrl, m_shift, key[8], key[SCAN_W-1:0]};
    apply_entry(map_copy[{idx, 1'b0}], rel);
    apply_entry(map_copy[{idx, 1'b1}], rel);
    repeat (SCAN_GAP) next_cycle();
    check_matrix(4);
  endtask

  task automatic run_cpu_op(input int kind, input logic [7:0] din, output logic [7:0] dout);
    int waited;
    check_value("cpu_ack", 32'(cpu_ack), 32'(0));
    cpu_din    = din;
    cpu_read   = (kind == 0);
    cpu_write  = (kind == 1);
    cpu_rewind = (kind == 2);
    waited = 0;
    next_cycle();
    while (cpu_ack !== 1'b1 && waited < ACK_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (cpu_ack !== 1'b1) begin
      errors++;
      $display("cpu_ack did not rise within %0d cycles of a request", ACK_LIMIT);
    end
    dout       = cpu_dout;
    cpu_read   = 1'b0;
    cpu_write  = 1'b0;
    cpu_rewind = 1'b0;
    next_cycle();
    check_value("cpu_ack", 32'(cpu_ack), 32'(0));
  endtask

  task automatic rewind_keymap();
    logic [7:0] unused;
    run_cpu_op(2, 8'h00, unused);
  endtask

  task automatic write_keymap(input int addr, input logic [7:0] data);
    logic [7:0] unused;
    map_copy[addr] = data;
    run_cpu_op(1, data, unused);
  endtask

  task automatic read_keymap(input int addr);
    logic [7:0] data;
    run_cpu_op(0, 8'h00, data);
    check_value("cpu_dout", 32'(data), 32'(map_copy[addr]));
  endtask

  // Steps the address up to addr by reading the entries in front of it
  task automatic seek_keymap(input int addr);
    rewind_keymap();
    for (int a = 0; a < addr; a++) begin
      read_keymap(a);
    end
  endtask

  task automatic wait_all_ones(input int limit);
    int n;
    sp_row = 8'h00;
    n = 0;
    checks++;
    while (sp_col !== '1 && n < limit) begin
      next_cycle();
      n++;
    end
    if (sp_col !== '1) begin
      errors++;
      $display("Matrix did not return to all ones within %0d cycles", limit);
    end
    for (int r = 0; r < MATRIX_ROWS; r++) begin
      model_rows[r] = '1;
    end
    check_matrix(4);
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [KEY_CODE_W-1:0] pool [10];
    logic                  held [10];
    int                    start_err;
    int                    r;
    void'($urandom(13068));
    rst = 1'b1;
    scan_received = 1'b0;
    scan_code = '0;
    extended = 1'b0;
    released = 1'b0;
    sp_row = '1;
    cpu_din = '0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    cpu_rewind = 1'b0;
    check_en = 1'b0;
    errors = 0;
    checks = 0;
    m_shift = 1'b0;
    m_ctrl = 1'b0;
    m_alt = 1'b0;
    for (int a = 0; a < CPU_DEPTH; a++) begin
      map_copy[a] = 8'h00;
    end
    for (int i = 0; i < MATRIX_ROWS; i++) begin
      model_rows[i] = '1;
    end
    pool = '{9'h01C, 9'h032, 9'h021, 9'h023, 9'h024, 9'h02B, 9'h034, 9'h033,
             9'h16B, 9'h174};
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2) next_cycle();

    start_err = errors;
    // Every half-row selection pattern in turn
    for (int p = 0; p < 2**MATRIX_ROWS; p++) begin
      sp_row   = 8'(p);
      check_en = 1'b1;
      next_cycle();
    end
    check_en = 1'b0;
    check_specials(8'h00);
    check_value("cpu_ack", 32'(cpu_ack), 32'(0));
    $display("Test 1 reset state: finished with %0d errors", errors - start_err);

    start_err = errors;
    rewind_keymap();
    for (int a = 0; a < CPU_DEPTH; a++) begin
      write_keymap(a, 8'($urandom()));
    end
    rewind_keymap();
    for (int a = 0; a < CPU_DEPTH; a++) begin
      read_keymap(a);
    end
    $display("Test 2 keymap write and read back: finished with %0d errors", errors - start_err);

    start_err = errors;
    for (int i = 0; i < 10; i++) begin
      held[i] = 1'b0;
    end
    for (int e = 0; e < EVENTS; e++) begin
      r = int'($urandom() % 13);
      if (r < 10) begin
        send_key(pool[r], held[r]);
        held[r] = !held[r];
      end else if (r == 10) begin
        send_key(KEY_LSHIFT, m_shift);
      end else if (r == 11) begin
        send_key(KEY_LCTRL, m_ctrl);
      end else begin
        send_key(KEY_LALT, m_alt);
      end
    end
    for (int i = 0; i < 10; i++) begin
      if (held[i]) send_key(pool[i], 1'b1);
    end
    if (m_shift) send_key(KEY_LSHIFT, 1'b1);
    if (m_ctrl) send_key(KEY_LCTRL, 1'b1);
    if (m_alt) send_key(KEY_LALT, 1'b1);
    wait_all_ones(400);
    $display("Test 3 random key translation: finished with %0d errors", errors - start_err);

    start_err = errors;
    send_key(KEY_PAD8, 1'b0);
    check_specials(8'b1000_0000);
    send_key(KEY_PAD8, 1'b1);
    send_key(KEY_PAD7, 1'b0);
    check_specials(8'b1010_0000);
    send_key(KEY_PAD7, 1'b1);
    send_key(KEY_PAD9, 1'b0);
    check_specials(8'b1001_0000);
    send_key(KEY_PAD9, 1'b1);
    send_key(KEY_PAD1, 1'b0);
    check_specials(8'b0110_0000);
    send_key(KEY_PAD1, 1'b1);
    send_key(KEY_PAD3, 1'b0);
    check_specials(8'b0101_0000);
    send_key(KEY_PAD3, 1'b1);
    send_key(KEY_PAD5, 1'b0);
    check_specials(8'b0100_0000);
    send_key(KEY_PAD5, 1'b1);
    send_key(KEY_LALT, 1'b0);
    check_specials(8'b0000_1000);
    send_key(KEY_LALT, 1'b1);
    send_key(KEY_F5, 1'b0);
    check_specials(8'b0000_0100);
    send_key(KEY_F5, 1'b1);
    send_key(KEY_DEL, 1'b0);
    check_specials(8'b0000_0000);
    send_key(KEY_DEL, 1'b1);
    send_key(KEY_LCTRL, 1'b0);
    send_key(KEY_LALT, 1'b0);
    send_key(KEY_DEL, 1'b0);
    check_specials(8'b0000_1010);
    send_key(KEY_DEL, 1'b1);
    check_specials(8'b0000_1000);
    send_key(KEY_BACKSPACE, 1'b0);
    check_specials(8'b0000_1001);
    send_key(KEY_BACKSPACE, 1'b1);
    send_key(KEY_LALT, 1'b1);
    send_key(KEY_LCTRL, 1'b1);
    check_specials(8'b0000_0000);
    wait_all_ones(400);
    $display("Test 4 special keys: finished with %0d errors", errors - start_err);

    // Key 0x1C with no modifiers sits at entry 0x1C, CPU address 0x38
    start_err = errors;
    seek_keymap(12'h038);
    write_keymap(12'h038, {3'd3, 5'b00001});
    write_keymap(12'h039, 8'h00);
    send_key(9'h01C, 1'b0);
    seek_keymap(12'h038);
    write_keymap(12'h038, {3'd3, 5'b00010});
    send_key(9'h01C, 1'b1);
    // The release was sampled SCAN_GAP + 4 cycles before this wait starts
    wait_all_ones(400 - SCAN_GAP - 4);
    $display("Test 5 stuck key recovery: finished with %0d errors", errors - start_err);

    $display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/kbd_top.sv
module kbd_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            scan_received,
  input  logic [kbd_pkg::SCAN_W-1:0]      scan_code,
  input  logic                            extended,
  input  logic                            released,
  input  logic [kbd_pkg::MATRIX_ROWS-1:0] sp_row,
  output logic [kbd_pkg::MATRIX_COLS-1:0] sp_col,
  input  logic [7:0]                      cpu_din,
  output logic [7:0]                      cpu_dout,
  input  logic                            cpu_read,
  input  logic                            cpu_write,
  input  logic                            cpu_rewind,
  output logic                            cpu_ack,
  output logic                            user_reset,
  output logic                            master_reset,
  output logic                            user_nmi,
  output logic                            joy_up,
  output logic                            joy_down,
  output logic                            joy_left,
  output logic                            joy_right,
  output logic                            joy_fire
);
  import kbd_pkg::*;

  logic                     shift_pressed;
  logic                     ctrl_pressed;
  logic                     alt_pressed;
  logic                     kb_clean;
  logic [KEYMAP_ADDR_W-1:0] ram_addr;
  logic                     ram_wr_en;
  logic                     ram_wr_map_sel;
  keymap_entry_t            ram_wr_data;
  keymap_entry_t            rd_data1;
  keymap_entry_t            rd_data2;
  logic                     mtx_clear;
  logic                     mtx_upd_en;
  logic [ROW_SEL_W-1:0]     mtx_upd_row;
  logic [MATRIX_COLS-1:0]   mtx_upd_cols;
  logic                     mtx_upd_release;

  special_keys special_keys_inst (
    .clk, .rst, .scan_received, .scan_code, .extended, .released,
    .shift_pressed, .ctrl_pressed, .alt_pressed,
    .user_reset, .master_reset, .user_nmi,
    .joy_up, .joy_down, .joy_left, .joy_right, .joy_fire
  );

  key_activity_monitor key_activity_monitor_inst (
    .clk, .rst, .scan_received, .scan_code, .extended, .released, .kb_clean
  );

  translate_ctrl translate_ctrl_inst (
    .clk, .rst, .scan_received, .scan_code, .extended, .released,
    .shift_pressed, .ctrl_pressed, .alt_pressed, .kb_clean,
    .rd_data1, .rd_data2, .cpu_din, .cpu_read, .cpu_write, .cpu_rewind,
    .ram_addr, .ram_wr_en, .ram_wr_map_sel, .ram_wr_data,
    .mtx_clear, .mtx_upd_en, .mtx_upd_row, .mtx_upd_cols, .mtx_upd_release,
    .cpu_dout, .cpu_ack
  );

  keymap_ram keymap_ram_inst (
    .clk,
    .addr       (ram_addr),
    .wr_en      (ram_wr_en),
    .wr_map_sel (ram_wr_map_sel),
    .wr_data    (ram_wr_data),
    .rd_data1,
    .rd_data2
  );

  spectrum_matrix spectrum_matrix_inst (
    .clk,
    .clear       (mtx_clear),
    .upd_en      (mtx_upd_en),
    .upd_row     (mtx_upd_row),
    .upd_cols    (mtx_upd_cols),
    .upd_release (mtx_upd_release),
    .sp_row,
    .sp_col
  );

endmodule

//--- rtl/translate_ctrl.sv
module translate_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              scan_received,
  input  logic [kbd_pkg::SCAN_W-1:0]        scan_code,
  input  logic                              extended,
  input  logic                              released,
  input  logic                              shift_pressed,
  input  logic                              ctrl_pressed,
  input  logic                              alt_pressed,
  input  logic                              kb_clean,
  input  kbd_pkg::keymap_entry_t            rd_data1,
  input  kbd_pkg::keymap_entry_t            rd_data2,
  input  logic [7:0]                        cpu_din,
  input  logic                              cpu_read,
  input  logic                              cpu_write,
  input  logic                              cpu_rewind,
  output logic [kbd_pkg::KEYMAP_ADDR_W-1:0] ram_addr,
  output logic                              ram_wr_en,
  output logic                              ram_wr_map_sel,
  output kbd_pkg::keymap_entry_t            ram_wr_data,
  output logic                              mtx_clear,
  output logic                              mtx_upd_en,
  output logic [kbd_pkg::ROW_SEL_W-1:0]     mtx_upd_row,
  output logic [kbd_pkg::MATRIX_COLS-1:0]   mtx_upd_cols,
  output logic                              mtx_upd_release,
  output logic [7:0]                        cpu_dout,
  output logic                              cpu_ack
);
  import kbd_pkg::*;

  typedef enum logic [3:0] {
    ST_CLEAN,
    ST_IDLE,
    ST_LOOKUP,
    ST_KEY1,
    ST_KEY2,
    ST_CPU,
    ST_READ,
    ST_WRITE,
    ST_WAIT
  } state_t;

  state_t                  state;
  logic                    pending;
  logic [SCAN_W-1:0]       lat_scan;
  logic                    lat_ext;
  logic                    lat_rel;
  logic                    key_rel;
  logic [CPU_ADDR_W-1:0]   cpu_addr;
  logic                    rewind_op;
  logic                    cpu_req;
  logic [KEYMAP_ADDR_W-1:0] lookup_idx;

  assign cpu_req    = cpu_read | cpu_write | cpu_rewind;
  assign lookup_idx = {alt_pressed, ctrl_pressed, shift_pressed, lat_ext, lat_scan};

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_CLEAN;
      pending   <= 1'b0;
      cpu_ack   <= 1'b0;
      cpu_addr  <= '0;
      rewind_op <= 1'b0;
    end else begin
      if (scan_received) begin
        pending <= 1'b1;
      end else if (state == ST_IDLE && pending) begin
        pending <= 1'b0;
      end
      case (state)
        ST_CLEAN: state <= ST_IDLE;
        ST_IDLE: begin
          // Scans win over the CPU, and the wipe only runs with nothing to do
          if (pending) begin
            state <= ST_LOOKUP;
          end else if (cpu_req) begin
            state <= ST_CPU;
          end else if (kb_clean) begin
            state <= ST_CLEAN;
          end
        end
        ST_LOOKUP: state <= ST_KEY1;
        ST_KEY1:   state <= ST_KEY2;
        ST_KEY2:   state <= ST_IDLE;
        ST_CPU: begin
          rewind_op <= cpu_rewind;
          if (cpu_rewind) begin
            cpu_addr <= '0;
            cpu_ack  <= 1'b1;
            state    <= ST_WAIT;
          end else if (cpu_read) begin
            state <= ST_READ;
          end else if (cpu_write) begin
            state <= ST_WRITE;
          end else begin
            state <= ST_IDLE;
          end
        end
        ST_READ, ST_WRITE: begin
          cpu_ack <= 1'b1;
          state   <= ST_WAIT;
        end
        ST_WAIT: begin
          // The address steps on once the CPU has let go of its request
          if (!cpu_req) begin
            cpu_ack <= 1'b0;
            if (!rewind_op) begin
              cpu_addr <= cpu_addr + 1'b1;
            end
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Scan latch, keymap address and read data
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (scan_received) begin
      lat_scan <= scan_code;
      lat_ext  <= extended;
      lat_rel  <= released;
    end
    if (state == ST_IDLE) begin
      if (pending) begin
        ram_addr <= lookup_idx;
        key_rel  <= lat_rel;
      end else begin
        ram_addr <= cpu_addr[CPU_ADDR_W-1:1];
      end
    end
    if (state == ST_READ) begin
      cpu_dout <= cpu_addr[0] ? rd_data2 : rd_data1;
    end
  end

  assign mtx_clear       = (state == ST_CLEAN);
  assign mtx_upd_en      = (state == ST_KEY1) || (state == ST_KEY2);
  assign mtx_upd_row     = (state == ST_KEY2) ? rd_data2.row : rd_data1.row;
  assign mtx_upd_cols    = (state == ST_KEY2) ? rd_data2.cols : rd_data1.cols;
  assign mtx_upd_release = key_rel;
  assign ram_wr_en       = (state == ST_WRITE);
  assign ram_wr_map_sel  = cpu_addr[0];
  assign ram_wr_data     = keymap_entry_t'(cpu_din);

  // The ack is registered, so the request is the one seen on the edge that set it
  a_ack_needs_request : assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_ack) |-> $past(cpu_req))
    else $error("cpu_ack raised with no CPU request");

endmodule

//--- rtl/special_keys.sv
module special_keys (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       scan_received,
  input  logic [kbd_pkg::SCAN_W-1:0] scan_code,
  input  logic                       extended,
  input  logic                       released,
  output logic                       shift_pressed,
  output logic                       ctrl_pressed,
  output logic                       alt_pressed,
  output logic                       user_reset,
  output logic                       master_reset,
  output logic                       user_nmi,
  output logic                       joy_up,
  output logic                       joy_down,
  output logic                       joy_left,
  output logic                       joy_right,
  output logic                       joy_fire
);
  import kbd_pkg::*;

  logic [KEY_CODE_W-1:0] key_code;
  logic                  press;
  logic                  ctrl_alt;

  assign key_code = {extended, 1'b0, scan_code};
  assign press    = !released;
  assign ctrl_alt = ctrl_pressed && alt_pressed;

  always_ff @(posedge clk) begin
    if (rst) begin
      shift_pressed <= 1'b0;
      ctrl_pressed  <= 1'b0;
      alt_pressed   <= 1'b0;
      user_reset    <= 1'b0;
      master_reset  <= 1'b0;
      user_nmi      <= 1'b0;
      joy_up        <= 1'b0;
      joy_down      <= 1'b0;
      joy_left      <= 1'b0;
      joy_right     <= 1'b0;
      joy_fire      <= 1'b0;
    end else if (scan_received) begin
      case (key_code)
        KEY_LSHIFT, KEY_RSHIFT: shift_pressed <= press;
        KEY_LCTRL, KEY_RCTRL:   ctrl_pressed <= press;
        KEY_LALT, KEY_RALT: begin
          alt_pressed <= press;
          joy_fire    <= press;
        end
        KEY_BACKSPACE:          master_reset <= press && ctrl_alt;
        KEY_DEL, KEY_PAD_DEL:   user_reset <= press && ctrl_alt;
        KEY_F5:                 user_nmi <= press;
        KEY_PAD8:               joy_up <= press;
        KEY_PAD2, KEY_PAD5:     joy_down <= press;
        KEY_PAD4:               joy_left <= press;
        KEY_PAD6:               joy_right <= press;
        // Diagonals drive two directions at once
        KEY_PAD7: begin
          joy_up   <= press;
          joy_left <= press;
        end
        KEY_PAD9: begin
          joy_up    <= press;
          joy_right <= press;
        end
        KEY_PAD1: begin
          joy_down <= press;
          joy_left <= press;
        end
        KEY_PAD3: begin
          joy_down  <= press;
          joy_right <= press;
        end
        default: ;
      endcase
    end
  end

  a_reset_needs_ctrl_alt : assert property (@(posedge clk) disable iff (rst)
    ($rose(user_reset) || $rose(master_reset)) |-> (ctrl_pressed && alt_pressed))
    else $error("reset output raised without ctrl and alt held");

endmodule

//--- rtl/key_activity_monitor.sv
module key_activity_monitor (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       scan_received,
  input  logic [kbd_pkg::SCAN_W-1:0] scan_code,
  input  logic                       extended,
  input  logic                       released,
  output logic                       kb_clean
);
  import kbd_pkg::*;

  logic [2**SCAN_W-1:0] pressed_ne;
  logic [2**SCAN_W-1:0] pressed_ex;
  logic [SCAN_W-1:0]    sweep_addr;
  logic                 wiping;
  logic                 any_pressed;
  logic                 bit_pressed;

  assign bit_pressed = pressed_ne[sweep_addr] | pressed_ex[sweep_addr];

  // Scans that arrive during the wipe are not recorded
  always_ff @(posedge clk) begin
    if (wiping) begin
      pressed_ne[sweep_addr] <= 1'b0;
      pressed_ex[sweep_addr] <= 1'b0;
    end else if (scan_received) begin
      if (extended) begin
        pressed_ex[scan_code] <= !released;
      end else begin
        pressed_ne[scan_code] <= !released;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wiping      <= 1'b1;
      sweep_addr  <= '0;
      any_pressed <= 1'b0;
      kb_clean    <= 1'b0;
    end else if (wiping) begin
      sweep_addr <= sweep_addr + 1'b1;
      if (&sweep_addr) begin
        wiping   <= 1'b0;
        kb_clean <= 1'b1;
      end
    end else if (scan_received) begin
      // Any key event restarts the sweep from the first address
      sweep_addr  <= '0;
      any_pressed <= 1'b0;
      kb_clean    <= 1'b0;
    end else begin
      sweep_addr <= sweep_addr + 1'b1;
      if (&sweep_addr) begin
        kb_clean    <= !(any_pressed | bit_pressed);
        any_pressed <= 1'b0;
      end else begin
        any_pressed <= any_pressed | bit_pressed;
      end
    end
  end

endmodule

//--- rtl/spectrum_matrix.sv
module spectrum_matrix (
  input  logic                            clk,
  input  logic                            clear,
  input  logic                            upd_en,
  input  logic [kbd_pkg::ROW_SEL_W-1:0]   upd_row,
  input  logic [kbd_pkg::MATRIX_COLS-1:0] upd_cols,
  input  logic                            upd_release,
  input  logic [kbd_pkg::MATRIX_ROWS-1:0] sp_row,
  output logic [kbd_pkg::MATRIX_COLS-1:0] sp_col
);
  import kbd_pkg::*;

  // A zero bit means the key is held down
  logic [MATRIX_COLS-1:0] rows [MATRIX_ROWS];

  always_ff @(posedge clk) begin
    if (clear) begin
      for (int r = 0; r < MATRIX_ROWS; r++) begin
        rows[r] <= '1;
      end
    end else if (upd_en) begin
      if (upd_release) begin
        rows[upd_row] <= rows[upd_row] | upd_cols;
      end else begin
        rows[upd_row] <= rows[upd_row] & ~upd_cols;
      end
    end
  end

  // Every half-row selected by a low sp_row bit pulls its columns down
  always_comb begin
    sp_col = '1;
    for (int r = 0; r < MATRIX_ROWS; r++) begin
      if (!sp_row[r]) begin
        sp_col = sp_col & rows[r];
      end
    end
  end

  a_clear_excludes_update : assert property (@(posedge clk) clear |-> !upd_en)
    else $error("matrix clear and key update in the same cycle");

endmodule

//--- rtl/keymap_ram.sv
module keymap_ram (
  input  logic                              clk,
  input  logic [kbd_pkg::KEYMAP_ADDR_W-1:0] addr,
  input  logic                              wr_en,
  input  logic                              wr_map_sel,
  input  kbd_pkg::keymap_entry_t            wr_data,
  output kbd_pkg::keymap_entry_t            rd_data1,
  output kbd_pkg::keymap_entry_t            rd_data2
);
  import kbd_pkg::*;

  // Map 1 holds the first Spectrum key of a PC key, map 2 the second
  keymap_entry_t map1 [KEYMAP_DEPTH];
  keymap_entry_t map2 [KEYMAP_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en && !wr_map_sel) begin
      map1[addr] <= wr_data;
    end
    if (wr_en && wr_map_sel) begin
      map2[addr] <= wr_data;
    end
    rd_data1 <= map1[addr];
    rd_data2 <= map2[addr];
  end

  // The controller state is only defined from the first reset edge on
  a_wr_en_known : assert property (@(posedge clk) ##1 !$isunknown(wr_en))
    else $error("keymap write enable is unknown");

endmodule

//--- rtl/kbd_pkg.sv
package kbd_pkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int SCAN_W        = 7;
  localparam int KEY_CODE_W    = 9;
  localparam int MATRIX_ROWS   = 8;
  localparam int MATRIX_COLS   = 5;
  localparam int ROW_SEL_W     = 3;
  localparam int KEYMAP_ADDR_W = 11;
  localparam int KEYMAP_DEPTH  = 2048;
  localparam int CPU_ADDR_W    = 12;

  // One keymap byte names a Spectrum half-row and the keys pressed in it
  typedef struct packed {
    logic [ROW_SEL_W-1:0]   row;
    logic [MATRIX_COLS-1:0] cols;
  } keymap_entry_t;

  // ----------------------------------------
  // Key codes with the extended flag in bit 8
  // ----------------------------------------
  localparam logic [KEY_CODE_W-1:0] KEY_LSHIFT    = 9'h012;
  localparam logic [KEY_CODE_W-1:0] KEY_RSHIFT    = 9'h059;
  localparam logic [KEY_CODE_W-1:0] KEY_LCTRL     = 9'h014;
  localparam logic [KEY_CODE_W-1:0] KEY_RCTRL     = 9'h114;
  localparam logic [KEY_CODE_W-1:0] KEY_LALT      = 9'h011;
  localparam logic [KEY_CODE_W-1:0] KEY_RALT      = 9'h111;
  localparam logic [KEY_CODE_W-1:0] KEY_BACKSPACE = 9'h066;
  localparam logic [KEY_CODE_W-1:0] KEY_DEL       = 9'h171;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD_DEL   = 9'h071;
  localparam logic [KEY_CODE_W-1:0] KEY_F5        = 9'h003;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD1      = 9'h069;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD2      = 9'h072;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD3      = 9'h07A;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD4      = 9'h06B;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD5      = 9'h073;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD6      = 9'h074;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD7      = 9'h06C;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD8      = 9'h075;
  localparam logic [KEY_CODE_W-1:0] KEY_PAD9      = 9'h07D;

endpackage
